/* exu_pkg.sv */
// exu_pkg: tag and data widths, unit class and alu mode enums, issue, unit request and writeback structs
package exu_pkg;

	localparam int TAG_W = 8; // instruction tag width

	typedef logic [TAG_W-1:0] tag_t; // instruction tag
	typedef logic [31:0] word_t; // data word
	typedef logic [32:0] xword_t; // operand with sign/zero extension bit

	// execution unit selected by the decoder
	typedef enum logic [1:0] {
		class_alu     = 2'd0,
		class_mul     = 2'd1,
		class_div     = 2'd2,
		class_illegal = 2'd3
	} fu_class_t;

	// alu operation, same encoding as the decoder's op mode field
	typedef enum logic [3:0] {
		mode_add  = 4'd0,
		mode_sub  = 4'd1,
		mode_slt  = 4'd4, // signed less than
		mode_sltu = 4'd6, // unsigned less than
		mode_xor  = 4'd8,
		mode_or   = 4'd9,
		mode_and  = 4'd10,
		mode_sll  = 4'd11,
		mode_srl  = 4'd12,
		mode_sra  = 4'd13
	} alu_mode_t;

	typedef struct packed {
		tag_t      tag;
		fu_class_t cls;
		alu_mode_t alu_mode;
		word_t     op1;
		word_t     op2;
		logic      a_unsgn; // op1 unsigned for mul/div
		logic      b_unsgn; // op2 unsigned for mul/div
		logic      sel_hi_rem; // high product half or remainder
	} issue_t;

	typedef struct packed {
		tag_t      tag;
		alu_mode_t alu_mode;
		word_t     op1;
		word_t     op2;
		logic      err; // illegal instr, result forced to zero
	} alu_req_t;

	typedef struct packed {
		tag_t   tag;
		xword_t op_a;
		xword_t op_b;
		logic   sel_hi; // 1 = bits 63:32 of product
	} mul_req_t;

	typedef struct packed {
		tag_t   tag;
		xword_t op_a; // dividend
		xword_t op_b; // divisor
		logic   sel_rem; // 1 = remainder, 0 = quotient
	} div_req_t;

	typedef struct packed {
		tag_t  tag;
		word_t data;
		logic  err;
	} wb_t;

endpackage

/* dispatch.sv */
// dispatch: class decode, unit valid steering, ready mux and 33-bit operand extension
`timescale 1ns/100ps

module dispatch import exu_pkg::*; (
	input  issue_t   issue,
	input  logic     issue_valid,
	output logic     issue_ready,
	output alu_req_t alu_req,
	output logic     alu_valid,
	input  logic     alu_ready,
	output mul_req_t mul_req,
	output logic     mul_valid,
	input  logic     mul_ready,
	output div_req_t div_req,
	output logic     div_valid,
	input  logic     div_ready
);

	logic   is_illegal; // no unit knows this opcode
	xword_t a_x; // op1 extended
	xword_t b_x; // op2 extended

	assign is_illegal = (issue.cls == class_illegal);

	// extension bit is the sign bit unless flagged unsigned
	assign a_x = {~issue.a_unsgn & issue.op1[31], issue.op1};
	assign b_x = {~issue.b_unsgn & issue.op2[31], issue.op2};

	// illegal instrs still go down the alu path so they get written back
	assign alu_valid = issue_valid & ((issue.cls == class_alu) | is_illegal);
	assign mul_valid = issue_valid & (issue.cls == class_mul);
	assign div_valid = issue_valid & (issue.cls == class_div);

	always_comb begin
		case (issue.cls)
			class_mul: issue_ready = mul_ready;
			class_div: issue_ready = div_ready;
			default:   issue_ready = alu_ready; // alu and illegal
		endcase
	end

	always_comb begin
		alu_req.tag      = issue.tag;
		alu_req.alu_mode = is_illegal ? mode_add : issue.alu_mode; // mode field is junk when illegal
		alu_req.op1      = issue.op1;
		alu_req.op2      = issue.op2;
		alu_req.err      = is_illegal;

		mul_req.tag    = issue.tag;
		mul_req.op_a   = a_x;
		mul_req.op_b   = b_x;
		mul_req.sel_hi = issue.sel_hi_rem;

		div_req.tag     = issue.tag;
		div_req.op_a    = a_x;
		div_req.op_b    = b_x;
		div_req.sel_rem = issue.sel_hi_rem;
	end

endmodule

/* alu.sv */
// alu: single-cycle integer alu with result hold register and writeback request
`timescale 1ns/100ps

module alu import exu_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  alu_req_t req,
	input  logic     valid,
	output logic     ready,
	output wb_t      res,
	output logic     res_req,
	input  logic     gnt
);

	word_t alu_y; // combinational result
	logic  accept;

	assign ready  = ~res_req | gnt; // hold reg frees up on the grant cycle
	assign accept = valid & ready;

	always_comb begin
		case (req.alu_mode)
			mode_add:  alu_y = req.op1 + req.op2;
			mode_sub:  alu_y = req.op1 - req.op2;
			mode_xor:  alu_y = req.op1 ^ req.op2;
			mode_or:   alu_y = req.op1 | req.op2;
			mode_and:  alu_y = req.op1 & req.op2;
			mode_sll:  alu_y = req.op1 << req.op2[4:0]; // shamt is low 5 bits
			mode_srl:  alu_y = req.op1 >> req.op2[4:0];
			mode_sra:  alu_y = word_t'($signed(req.op1) >>> req.op2[4:0]);
			mode_slt:  alu_y = {31'd0, $signed(req.op1) < $signed(req.op2)};
			mode_sltu: alu_y = {31'd0, req.op1 < req.op2};
			default:   alu_y = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			res_req <= 1'b0;
		else if (accept)
			res_req <= 1'b1;
		else if (gnt)
			res_req <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			res.tag  <= req.tag;
			res.data <= req.err ? '0 : alu_y; // illegal writes back zero
			res.err  <= req.err;
		end
	end

	// result must not change under the arbiter until it is taken
	a_hold: assert property (@(posedge clk) disable iff (rst)
		res_req && !gnt |=> res_req && $stable(res));

endmodule

/* mul_unit.sv */
// mul_unit: 33x33 signed multiplier with MUL_STAGES delay pipeline and global stall
`timescale 1ns/100ps

module mul_unit import exu_pkg::*; #(
	parameter int MUL_STAGES = 3 // cycles from accept to req
) (
	input  logic     clk,
	input  logic     rst,
	input  mul_req_t req,
	input  logic     valid,
	output logic     ready,
	output wb_t      res,
	output logic     res_req,
	input  logic     gnt
);

	logic signed [65:0]   prod; // full signed product
	wb_t                  prod_res; // selected half, tagged
	logic [MUL_STAGES-1:0] stg_vld;
	wb_t  [MUL_STAGES-1:0] stg_res;
	logic                 stall;
	logic                 accept;

	assign prod = $signed({{33{req.op_a[32]}}, req.op_a})
		* $signed({{33{req.op_b[32]}}, req.op_b}); // unsigned ops have a zero ext bit

	assign prod_res.tag  = req.tag;
	assign prod_res.data = req.sel_hi ? prod[63:32] : prod[31:0];
	assign prod_res.err  = 1'b0;

	assign stall   = stg_vld[MUL_STAGES-1] & ~gnt; // last stage waits for the bus
	assign ready   = ~stall;
	assign accept  = valid & ready;
	assign res     = stg_res[MUL_STAGES-1];
	assign res_req = stg_vld[MUL_STAGES-1];

	always_ff @(posedge clk) begin
		if (rst) begin
			stg_vld <= '0;
		end else if (!stall) begin
			stg_vld[0] <= accept;
			for (int i = 1; i < MUL_STAGES; i++)
				stg_vld[i] <= stg_vld[i-1];
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			stg_res[0] <= prod_res;
			for (int i = 1; i < MUL_STAGES; i++)
				stg_res[i] <= stg_res[i-1];
		end
	end

	// a refused request waits with its operands unchanged
	a_no_acc: assert property (@(posedge clk) disable iff (rst)
		valid && !ready |=> valid && $stable(req));

endmodule

/* div_unit.sv */
// div_unit: 32-step restoring divider FSM with sign fixup and RISC-V divide corner cases
`timescale 1ns/100ps

module div_unit import exu_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  div_req_t req,
	input  logic     valid,
	output logic     ready,
	output wb_t      res,
	output logic     res_req,
	input  logic     gnt
);

	typedef enum logic [1:0] {idle, run, done} div_state_t;

	div_state_t  state;
	logic [4:0]  cnt; // step count
	logic        accept;
	word_t       mag_a; // |dividend|
	word_t       mag_b; // |divisor|
	tag_t        tag_q;
	logic        sel_rem_q;
	logic        neg_q; // quotient sign
	logic        neg_r; // remainder sign follows dividend
	logic        dvsr_zero;
	word_t       dvsr;
	word_t       quo; // dividend shifts out, quotient shifts in
	word_t       rem; // partial remainder
	logic [32:0] rem_sh;
	logic [33:0] diff; // bit 33 is the borrow
	word_t       q_fix;
	word_t       r_fix;

	assign ready   = (state == idle); // one divide at a time
	assign accept  = valid & ready;
	assign res_req = (state == done);

	// magnitude fits 32 bits, even for -2^31
	assign mag_a = req.op_a[32] ? (~req.op_a[31:0] + 32'd1) : req.op_a[31:0];
	assign mag_b = req.op_b[32] ? (~req.op_b[31:0] + 32'd1) : req.op_b[31:0];

	assign rem_sh = {rem, quo[31]};
	assign diff   = {1'b0, rem_sh} - {2'b00, dvsr};

	// x/0 gives all ones; remainder restores dividend by itself
	// -2^31/-1 gives 2^31 unsigned, i.e. the dividend, rem 0
	assign q_fix = dvsr_zero ? '1 : (neg_q ? -quo : quo);
	assign r_fix = neg_r ? -rem : rem;

	assign res.tag  = tag_q;
	assign res.data = sel_rem_q ? r_fix : q_fix;
	assign res.err  = 1'b0;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
			cnt   <= '0;
		end else begin
			case (state)
				idle: if (accept) begin
					state <= run;
					cnt   <= '0;
				end
				run: begin
					cnt <= cnt + 5'd1;
					if (cnt == 5'd31)
						state <= done; // 32 steps done
				end
				done: if (gnt)
					state <= idle;
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			tag_q     <= req.tag;
			sel_rem_q <= req.sel_rem;
			neg_q     <= req.op_a[32] ^ req.op_b[32];
			neg_r     <= req.op_a[32];
			dvsr_zero <= (req.op_b == '0);
			dvsr      <= mag_b;
			quo       <= mag_a;
			rem       <= '0;
		end else if (state == run) begin
			rem <= diff[33] ? rem_sh[31:0] : diff[31:0]; // restore on borrow
			quo <= {quo[30:0], ~diff[33]};
		end
	end

	// result only shows up after a full 32-cycle run
	a_done: assert property (@(posedge clk) disable iff (rst)
		$rose(res_req) |-> $past(state == run) && $past(state == run, 32));

endmodule

/* wb_arbiter.sv */
// wb_arbiter: fixed-priority grant of the shared writeback bus and registered wb output
`timescale 1ns/100ps

module wb_arbiter import exu_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  wb_t  alu_res,
	input  logic alu_req,
	output logic alu_gnt,
	input  wb_t  mul_res,
	input  logic mul_req,
	output logic mul_gnt,
	input  wb_t  div_res,
	input  logic div_req,
	output logic div_gnt,
	output wb_t  wb,
	output logic wb_valid
);

	// alu > mul > div, same-cycle grant
	assign alu_gnt = alu_req;
	assign mul_gnt = mul_req & ~alu_req;
	assign div_gnt = div_req & ~alu_req & ~mul_req;

	always_ff @(posedge clk) begin
		if (rst)
			wb_valid <= 1'b0;
		else
			wb_valid <= alu_req | mul_req | div_req; // something always wins
	end

	always_ff @(posedge clk) begin
		if (alu_gnt)
			wb <= alu_res;
		else if (mul_gnt)
			wb <= mul_res;
		else if (div_gnt)
			wb <= div_res;
	end

	// each wb pulse comes from exactly one grant
	a_one_gnt: assert property (@(posedge clk) disable iff (rst)
		wb_valid |-> $past($onehot({alu_gnt, mul_gnt, div_gnt})));

endmodule

/* exu_top.sv */
// exu_top: dispatch, alu, multiplier, divider and writeback arbiter
`timescale 1ns/100ps

module exu_top import exu_pkg::*; #(
	parameter int MUL_STAGES = 3 // multiplier depth
) (
	input  logic   clk,
	input  logic   rst,
	input  issue_t issue,
	input  logic   issue_valid,
	output logic   issue_ready,
	output wb_t    wb,
	output logic   wb_valid
);

	alu_req_t alu_in;
	logic     alu_in_valid, alu_in_ready;
	mul_req_t mul_in;
	logic     mul_in_valid, mul_in_ready;
	div_req_t div_in;
	logic     div_in_valid, div_in_ready;
	wb_t      alu_res, mul_res, div_res; // held unit results
	logic     alu_res_req, mul_res_req, div_res_req;
	logic     alu_gnt, mul_gnt, div_gnt;

	dispatch i_dispatch (
		.issue(issue), .issue_valid(issue_valid), .issue_ready(issue_ready),
		.alu_req(alu_in), .alu_valid(alu_in_valid), .alu_ready(alu_in_ready),
		.mul_req(mul_in), .mul_valid(mul_in_valid), .mul_ready(mul_in_ready),
		.div_req(div_in), .div_valid(div_in_valid), .div_ready(div_in_ready)
	);

	alu i_alu (
		.clk(clk), .rst(rst), .req(alu_in), .valid(alu_in_valid), .ready(alu_in_ready),
		.res(alu_res), .res_req(alu_res_req), .gnt(alu_gnt)
	);

	mul_unit #(.MUL_STAGES(MUL_STAGES)) i_mul (
		.clk(clk), .rst(rst), .req(mul_in), .valid(mul_in_valid), .ready(mul_in_ready),
		.res(mul_res), .res_req(mul_res_req), .gnt(mul_gnt)
	);

	div_unit i_div (
		.clk(clk), .rst(rst), .req(div_in), .valid(div_in_valid), .ready(div_in_ready),
		.res(div_res), .res_req(div_res_req), .gnt(div_gnt)
	);

	wb_arbiter i_arb (
		.clk(clk), .rst(rst),
		.alu_res(alu_res), .alu_req(alu_res_req), .alu_gnt(alu_gnt),
		.mul_res(mul_res), .mul_req(mul_res_req), .mul_gnt(mul_gnt),
		.div_res(div_res), .div_req(div_res_req), .div_gnt(div_gnt),
		.wb(wb), .wb_valid(wb_valid)
	);

endmodule

/* tb_exu_checker.sv */
// tb_exu_checker: reference model for issued instrs, issue_ready check and by-tag writeback comparator
`timescale 1ns/100ps

module tb_exu_checker import exu_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  issue_t issue,
	input  logic   issue_valid,
	input  logic   issue_ready,
	input  wb_t    wb,
	input  logic   wb_valid,
	input  logic   end_of_test, // scan for missing tags and report
	output int     outstanding, // issued but not yet written back
	output int     error_total, // final count, valid with report_done
	output logic   report_done
);

	wb_t exp_res [256]; // expected result per tag
	bit  issued [256];
	bit  seen [256]; // written back at least once
	int  n_issued;
	int  n_written;
	int  n_missing;
	int  n_dup;
	int  errors;
	bit   div_busy; // a divide sits between accept and writeback
	tag_t div_tag; // tag of that divide
	bit   div_free; // divider idle in the sampled cycle
	logic exp_ready; // expected issue_ready for the class on offer

	assign outstanding = n_issued - n_written;

	// expected writeback from the unit rules, per issued instr
	function automatic wb_t expect_result(issue_t i);
		logic signed [63:0] a; // op1 widened per its unsigned flag
		logic signed [63:0] b;
		logic signed [63:0] p;
		logic [63:0]        sx; // sign-extended op1 for sra
		wb_t                r;
		r.tag  = i.tag;
		r.err  = 1'b0;
		r.data = '0;
		a = i.a_unsgn ? {32'd0, i.op1} : {{32{i.op1[31]}}, i.op1};
		b = i.b_unsgn ? {32'd0, i.op2} : {{32{i.op2[31]}}, i.op2};
		case (i.cls)
			class_illegal: r.err = 1'b1; // data stays zero
			class_mul: begin
				p = a * b; // low 64 bits are exact even on wrap
				r.data = i.sel_hi_rem ? p[63:32] : p[31:0];
			end
			class_div: begin
				if (i.op2 == '0) begin
					r.data = i.sel_hi_rem ? i.op1 : '1; // x/0 rule
				end else begin
					p = i.sel_hi_rem ? a % b : a / b; // -2^31/-1 lands on 2^31
					r.data = p[31:0];
				end
			end
			default: begin
				case (i.alu_mode)
					mode_add:  r.data = i.op1 + i.op2;
					mode_sub:  r.data = i.op1 - i.op2;
					mode_xor:  r.data = i.op1 ^ i.op2;
					mode_or:   r.data = i.op1 | i.op2;
					mode_and:  r.data = i.op1 & i.op2;
					mode_sll:  r.data = i.op1 << i.op2[4:0];
					mode_srl:  r.data = i.op1 >> i.op2[4:0];
					mode_sra: begin
						sx = {{32{i.op1[31]}}, i.op1} >> i.op2[4:0];
						r.data = sx[31:0];
					end
					mode_slt:  r.data = {31'd0, (i.op1 ^ 32'h8000_0000) < (i.op2 ^ 32'h8000_0000)};
					mode_sltu: r.data = {31'd0, i.op1 < i.op2};
					default:   r.data = '0;
				endcase
			end
		endcase
		return r;
	endfunction

	always @(posedge clk) begin
		if (rst) begin
			n_issued    <= 0;
			n_written   <= 0;
			report_done <= 1'b0;
			error_total <= 0;
			errors = 0;
			n_missing = 0;
			n_dup = 0;
			div_busy = 1'b0;
		end else begin
			// alu tops the priority so never stalls, divider frees on its writeback
			div_free = !div_busy || (wb_valid && wb.tag == div_tag);
			if (issue_valid && issue.cls != class_mul) begin
				exp_ready = (issue.cls == class_div) ? div_free : 1'b1;
				if (issue_ready !== exp_ready) begin
					errors++;
					$display("ERROR issue_ready tag %h: got %h expected %h",
						issue.tag, issue_ready, exp_ready);
				end
			end
			if (wb_valid && div_busy && wb.tag == div_tag)
				div_busy = 1'b0;
			if (issue_valid && issue_ready && issue.cls == class_div) begin
				div_busy = 1'b1;
				div_tag  = issue.tag;
			end
			if (issue_valid && issue_ready) begin
				if (issued[issue.tag]) begin
					errors++;
					$display("tag %0d was issued a second time", issue.tag);
				end
				exp_res[issue.tag] = expect_result(issue);
				issued[issue.tag] = 1'b1;
				n_issued <= n_issued + 1;
			end
			if (wb_valid) begin
				if (!issued[wb.tag]) begin
					errors++;
					$display("write back of tag %0d which was never issued", wb.tag);
				end else if (seen[wb.tag]) begin
					errors++;
					n_dup++;
					$display("tag %0d was written back twice", wb.tag);
				end else begin
					seen[wb.tag] = 1'b1;
					n_written <= n_written + 1;
					if (wb.data !== exp_res[wb.tag].data) begin
						errors++;
						$display("ERROR wb.data tag %h: got %h expected %h",
							wb.tag, wb.data, exp_res[wb.tag].data);
					end
					if (wb.err !== exp_res[wb.tag].err) begin
						errors++;
						$display("ERROR wb.err tag %h: got %h expected %h",
							wb.tag, wb.err, exp_res[wb.tag].err);
					end
				end
			end
			if (end_of_test && !report_done) begin
				for (int t = 0; t < 256; t++) begin
					if (issued[t] && !seen[t]) begin
						errors++;
						n_missing++;
						$display("tag %0d was never written back", t);
					end
				end
				$display("checker: %0d issued, %0d written back, %0d missing, %0d duplicate, %0d errors",
					n_issued, n_written, n_missing, n_dup, errors);
				error_total <= errors;
				report_done <= 1'b1;
			end
		end
	end

endmodule

/* tb_exu_top.sv */
// tb_exu_top: clock, reset, stimulus table, issue loop with random bubbles, drain and verdict
`timescale 1ns/100ps

module tb_exu_top import exu_pkg::*; ();

	localparam int N_STIM = 48;
	localparam int ISSUE_TIMEOUT = 200; // cycles per handshake, divider is ~35
	localparam int DRAIN_TIMEOUT = 500;
	localparam int REPORT_TIMEOUT = 20;

	typedef struct packed {
		fu_class_t  cls;
		alu_mode_t  mode;
		word_t      op1;
		word_t      op2;
		logic [2:0] flags; // a_unsgn, b_unsgn, sel_hi_rem
	} stim_t;

	logic   clk;
	logic   rst;
	issue_t issue;
	logic   issue_valid;
	logic   issue_ready;
	wb_t    wb;
	logic   wb_valid;
	logic   end_of_test;
	int     outstanding;
	int     error_total;
	logic   report_done;
	stim_t  tbl [N_STIM];
	int     seed = 11;
	int     wait_cnt;
	int     idle_n; // bubble cycles before an entry
	bit     accepted;
	bit     timed_out;

	exu_top #(.MUL_STAGES(3)) i_dut (
		.clk(clk), .rst(rst), .issue(issue), .issue_valid(issue_valid),
		.issue_ready(issue_ready), .wb(wb), .wb_valid(wb_valid)
	);

	tb_exu_checker i_chk (
		.clk(clk), .rst(rst), .issue(issue), .issue_valid(issue_valid),
		.issue_ready(issue_ready), .wb(wb), .wb_valid(wb_valid),
		.end_of_test(end_of_test), .outstanding(outstanding),
		.error_total(error_total), .report_done(report_done)
	);

	always #5 clk = ~clk; // 10 ns period

	function automatic issue_t build_issue(int idx, stim_t s);
		issue_t r;
		r.tag        = tag_t'(idx); // tags just count up
		r.cls        = s.cls;
		r.alu_mode   = s.mode;
		r.op1        = s.op1;
		r.op2        = s.op2;
		r.a_unsgn    = s.flags[2];
		r.b_unsgn    = s.flags[1];
		r.sel_hi_rem = s.flags[0];
		return r;
	endfunction

	initial begin
		tbl = '{
			// alu: all modes, signed vs unsigned compares, shifts of 31 and up
			'{class_alu, mode_add, 32'h7fff_ffff, 32'h0000_0001, 3'b000},
			'{class_alu, mode_sub, 32'h0000_0000, 32'h0000_0001, 3'b000},
			'{class_alu, mode_xor, 32'hf0f0_f0f0, 32'h0ff0_0ff0, 3'b000},
			'{class_alu, mode_or, 32'h1234_0000, 32'h0000_5678, 3'b000},
			'{class_alu, mode_and, 32'hffff_0000, 32'h0f0f_0f0f, 3'b000},
			'{class_alu, mode_sll, 32'h0000_0001, 32'h0000_001f, 3'b000},
			'{class_alu, mode_sll, 32'h1234_5678, 32'h0000_0020, 3'b000},
			'{class_alu, mode_srl, 32'h8000_0000, 32'h0000_001f, 3'b000},
			'{class_alu, mode_srl, 32'hdead_beef, 32'h0000_003f, 3'b000},
			'{class_alu, mode_sra, 32'h8000_0000, 32'h0000_001f, 3'b000},
			'{class_alu, mode_sra, 32'h8000_f000, 32'hffff_ffe4, 3'b000},
			'{class_alu, mode_slt, 32'hffff_ffff, 32'h0000_0001, 3'b000},
			'{class_alu, mode_sltu, 32'hffff_ffff, 32'h0000_0001, 3'b000},
			'{class_alu, mode_slt, 32'h0000_0001, 32'h8000_0000, 3'b000},
			'{class_alu, mode_sltu, 32'h0000_0001, 32'h8000_0000, 3'b000},
			'{class_alu, mode_add, 32'hffff_ffff, 32'hffff_ffff, 3'b000},
			// mul: ss, su, uu in low and high halves
			'{class_mul, mode_add, 32'hffff_fffd, 32'h0000_0007, 3'b000},
			'{class_mul, mode_add, 32'hffff_fffd, 32'h0000_0007, 3'b001},
			'{class_mul, mode_add, 32'h8000_0000, 32'h8000_0000, 3'b001},
			'{class_mul, mode_add, 32'hffff_ffff, 32'hffff_ffff, 3'b011},
			'{class_mul, mode_add, 32'hffff_ffff, 32'hffff_ffff, 3'b010},
			'{class_mul, mode_add, 32'hffff_ffff, 32'hffff_ffff, 3'b111},
			'{class_mul, mode_add, 32'hffff_ffff, 32'hffff_ffff, 3'b110},
			'{class_mul, mode_add, 32'h1234_5678, 32'h9abc_def0, 3'b111},
			'{class_mul, mode_add, 32'h1234_5678, 32'h9abc_def0, 3'b000},
			// div: signed and unsigned, by zero, -2^31 / -1
			'{class_div, mode_add, 32'hffff_ffec, 32'h0000_0006, 3'b000},
			'{class_div, mode_add, 32'hffff_ffec, 32'h0000_0006, 3'b001},
			'{class_div, mode_add, 32'hffff_ffec, 32'h0000_0006, 3'b110},
			'{class_div, mode_add, 32'hffff_ffec, 32'h0000_0006, 3'b111},
			'{class_div, mode_add, 32'h0000_1234, 32'h0000_0000, 3'b000},
			'{class_div, mode_add, 32'hffff_ff00, 32'h0000_0000, 3'b001},
			'{class_div, mode_add, 32'hffff_ff00, 32'h0000_0000, 3'b110},
			'{class_div, mode_add, 32'hffff_ff00, 32'h0000_0000, 3'b111},
			'{class_div, mode_add, 32'h8000_0000, 32'hffff_ffff, 3'b000},
			'{class_div, mode_add, 32'h8000_0000, 32'hffff_ffff, 3'b001},
			'{class_div, mode_add, 32'h7fff_ffff, 32'hffff_fffe, 3'b000},
			'{class_div, mode_add, 32'h0000_0005, 32'hffff_fffd, 3'b001},
			// illegal: err set, data zero
			'{class_illegal, mode_sub, 32'hdead_beef, 32'h0000_0001, 3'b000},
			'{class_illegal, mode_add, 32'h0000_0000, 32'h0000_0000, 3'b000},
			// mixed tail for stalls and out of order returns
			'{class_div, mode_add, 32'h0000_0064, 32'h0000_0007, 3'b110},
			'{class_div, mode_add, 32'hffff_ffff, 32'h0000_0010, 3'b111},
			'{class_mul, mode_add, 32'h0000_0003, 32'h0000_0005, 3'b000},
			'{class_mul, mode_add, 32'hffff_ffff, 32'hffff_ffff, 3'b000},
			'{class_mul, mode_add, 32'h7fff_ffff, 32'h7fff_ffff, 3'b001},
			'{class_alu, mode_add, 32'h0000_0001, 32'h0000_0002, 3'b000},
			'{class_mul, mode_add, 32'h8000_0000, 32'h8000_0000, 3'b011},
			'{class_div, mode_add, 32'h8000_0000, 32'h0000_0002, 3'b000},
			'{class_alu, mode_sra, 32'h7fff_ffff, 32'h0000_003f, 3'b000}
		};
		clk         = 1'b0;
		rst         = 1'b1;
		issue       = '0;
		issue_valid = 1'b0;
		end_of_test = 1'b0;
		timed_out   = 1'b0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		for (int i = 0; i < N_STIM && !timed_out; i++) begin
			idle_n = 0;
			if (($random(seed) & 3) == 0)
				idle_n = 1 + ($random(seed) & 1); // 1 or 2 bubbles
			if (idle_n != 0) begin
				issue_valid <= 1'b0;
				repeat (idle_n) @(posedge clk);
			end
			issue       <= build_issue(i, tbl[i]);
			issue_valid <= 1'b1;
			accepted = 1'b0;
			wait_cnt = 0;
			while (!accepted && !timed_out) begin
				@(posedge clk);
				if (issue_ready) begin
					accepted = 1'b1; // transfer on this edge
				end else begin
					wait_cnt++;
					if (wait_cnt >= ISSUE_TIMEOUT) begin
						$display("timeout: entry %0d never saw issue_ready", i);
						timed_out = 1'b1;
					end
				end
			end
		end
		issue_valid <= 1'b0;

		// drain, first edge lets the last handshake reach the count
		wait_cnt = 0;
		do begin
			@(posedge clk);
			wait_cnt++;
		end while (!timed_out && outstanding != 0 && wait_cnt < DRAIN_TIMEOUT);
		if (!timed_out && outstanding != 0) begin
			$display("timeout: %0d results still outstanding after drain", outstanding);
			timed_out = 1'b1;
		end
		repeat (5) @(posedge clk); // room for a stray duplicate

		end_of_test <= 1'b1;
		wait_cnt = 0;
		do begin
			@(posedge clk);
			wait_cnt++;
		end while (!report_done && wait_cnt < REPORT_TIMEOUT);
		if (!report_done) begin
			$display("timeout: checker never gave its report");
			timed_out = 1'b1;
		end

		if (timed_out || error_total != 0)
			$display("Simulation failed");
		else
			$display("Simulation passed");
		$finish;
	end

endmodule

/* verilog.f */
exu_pkg.sv
dispatch.sv
alu.sv
mul_unit.sv
div_unit.sv
wb_arbiter.sv
exu_top.sv
tb_exu_checker.sv
tb_exu_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_exu_top
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
